// ==== build.f ====
verilog/soc_misc_pkg.sv
verilog/bus_decode.sv
verilog/board_regs.sv
verilog/gpio_regs.sv
verilog/flash_sel_seq.sv
verilog/soc_misc_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== verif/tb_checker.sv ====
// bus and pin checker for the misc page DUT
// predicts each response and every output pin from the register rules
`timescale 1ns/1ps

module tb_checker
	import soc_misc_pkg::*;
(
	input  logic        clk48m,
	input  logic        rst,
	input  bus_req_t    i_req,
	input  logic        i_exp_chk,
	input  word_t       i_exp_rdata,
	input  bus_rsp_t    i_rsp,
	input  logic        i_bus_error,
	input  logic [15:0] i_led,
	input  logic        i_trace_en,
	input  genio_t      i_genio_out,
	input  genio_t      i_genio_oe,
	input  sao_t        i_sao1_out,
	input  sao_t        i_sao1_oe,
	input  sao_t        i_sao2_out,
	input  sao_t        i_sao2_oe,
	input  pmod_t       i_pmod_out,
	input  pmod_t       i_pmod_oe,
	input  logic        i_irda_sd,
	input  logic        i_fsel_d,
	input  logic        i_fsel_c,
	input  logic        i_programn,
	output int          o_checks,
	output int          o_errors
);

	// response expected in the next cycle
	logic        pend;
	logic        pend_chk;
	logic        pend_berr;
	word_t       pend_rdata;
	// pin model
	logic [15:0] led_m;
	logic        trace_m;
	word_t       genio_m;
	word_t       genio_oe_m;
	word_t       ext_m;
	word_t       ext_oe_m;
	logic        fsel_d_m;
	logic        reload_armed;
	logic        programn_m;
	int          fsel_age;

	initial begin
		o_checks = 0;
		o_errors = 0;
	end

	task automatic check_val(input string name, input word_t got, input word_t exp);
		o_checks++;
		if (got !== exp) begin
			o_errors++;
			$display("error %s got %h expected %h", name, got, exp);
		end
	endtask

	// only the expansion fields that exist as pins survive a write
	function automatic word_t ext_fields(word_t w, logic with_irda);
		word_t f;
		f = '0;
		f[5:0]   = w[5:0];
		f[13:8]  = w[13:8];
		f[23:16] = w[23:16];
		f[30]    = w[30] & with_irda;
		return f;
	endfunction

	task automatic apply_write(input reg_idx_t idx, input word_t wd);
		case (idx)
			REG_LED:       led_m = wd[15:0];
			REG_SOC_VER:   trace_m = wd[0];
			REG_GENIO_OUT: genio_m = {2'b0, wd[29:0]};
			REG_GENIO_OE:  genio_oe_m = {2'b0, wd[29:0]};
			REG_GENIO_W2S: genio_m = genio_m | {2'b0, wd[29:0]};
			REG_GENIO_W2C: genio_m = genio_m & ~wd;
			REG_GPEXT_OUT: ext_m = ext_fields(wd, 1'b1);
			REG_GPEXT_OE:  ext_oe_m = ext_fields(wd, 1'b0);
			REG_GPEXT_W2S: ext_m = ext_m | ext_fields(wd, 1'b1);
			REG_GPEXT_W2C: ext_m = ext_m & ~wd;
			REG_FLASH_SEL: begin
				fsel_d_m = wd[0];
				fsel_age = -1;
				if (wd[31:8] == RELOAD_MAGIC)
					reload_armed = 1'b1;
			end
			default: ;
		endcase
	endtask

	// ------------------------------------------------------------------------
	// compare mid-cycle, then take this cycle's request into the model
	// ------------------------------------------------------------------------
	always @(negedge clk48m) begin
		if (rst) begin
			pend         = 1'b0;
			pend_chk     = 1'b0;
			pend_berr    = 1'b0;
			pend_rdata   = '0;
			led_m        = '0;
			trace_m      = 1'b0;
			genio_m      = '0;
			genio_oe_m   = '0;
			ext_m        = 32'h4000_0000;
			ext_oe_m     = '0;
			fsel_d_m     = 1'b0;
			reload_armed = 1'b0;
			programn_m   = 1'b1;
			fsel_age     = 1000;
		end else begin
			// age counts cycles after the flash select write edge
			if (fsel_age < 1000)
				fsel_age++;
			if (fsel_age == 7 && reload_armed)
				programn_m = 1'b0;
			check_val("o_rsp.ready", i_rsp.ready, pend);
			check_val("o_bus_error", i_bus_error, pend_berr);
			if (pend && pend_chk)
				check_val("o_rsp.rdata", i_rsp.rdata, pend_rdata);
			check_val("o_led", i_led, led_m);
			check_val("o_trace_en", i_trace_en, trace_m);
			check_val("o_genio_out", {2'b0, i_genio_out}, genio_m);
			check_val("o_genio_oe", {2'b0, i_genio_oe}, genio_oe_m);
			check_val("o_sao1_out", i_sao1_out, ext_m[5:0]);
			check_val("o_sao2_out", i_sao2_out, ext_m[13:8]);
			check_val("o_pmod_out", i_pmod_out, ext_m[23:16]);
			check_val("o_irda_sd", i_irda_sd, ext_m[30]);
			check_val("o_sao1_oe", i_sao1_oe, ext_oe_m[5:0]);
			check_val("o_sao2_oe", i_sao2_oe, ext_oe_m[13:8]);
			check_val("o_pmod_oe", i_pmod_oe, ext_oe_m[23:16]);
			check_val("o_fsel_d", i_fsel_d, fsel_d_m);
			check_val("o_fsel_c", i_fsel_c, fsel_age >= 3 && fsel_age <= 5);
			check_val("o_programn", i_programn, programn_m);
			pend       = i_req.valid;
			pend_chk   = i_exp_chk;
			pend_rdata = i_exp_rdata;
			pend_berr  = i_req.valid && (i_req.addr[31:28] != REGION_MISC);
			if (i_req.valid && i_req.addr[31:28] == REGION_MISC && i_req.wstrb[0])
				apply_write(i_req.addr[6:2], i_req.wdata);
		end
	end

endmodule

// ==== verif/tb_top.sv ====
// testbench top for the misc page with clock, reset, table driven requests and summary
// responses and pins are judged by tb_checker
`timescale 1ns/1ps

module tb_top
	import soc_misc_pkg::*;
();

	typedef struct packed {
		logic       wr;
		word_t      addr;
		word_t      wdata;
		strb_t      wstrb;
		logic       chk;
		word_t      exp;
		logic [7:0] gap;
	} stim_t;

	logic        clk48m;
	logic        rst;
	bus_req_t    i_req;
	logic [7:0]  i_btn;
	genio_t      i_genio_in;
	sao_t        i_sao1_in;
	sao_t        i_sao2_in;
	pmod_t       i_pmod_in;
	logic        i_usb_vdet;
	bus_rsp_t    o_rsp;
	logic        o_bus_error;
	logic [15:0] o_led;
	logic        o_trace_en;
	genio_t      o_genio_out;
	genio_t      o_genio_oe;
	sao_t        o_sao1_out;
	sao_t        o_sao1_oe;
	sao_t        o_sao2_out;
	sao_t        o_sao2_oe;
	pmod_t       o_pmod_out;
	pmod_t       o_pmod_oe;
	logic        o_irda_sd;
	logic        o_fsel_d;
	logic        o_fsel_c;
	logic        o_programn;
	logic        exp_chk;
	word_t       exp_rdata;
	int          checks;
	int          errors;
	integer      seed;
	int          cycles = 0;
	int          limit = 1000;
	stim_t       stim_q[$];

	soc_misc_top DUT (.*);

	tb_checker u_checker (
		.clk48m      (clk48m),
		.rst         (rst),
		.i_req       (i_req),
		.i_exp_chk   (exp_chk),
		.i_exp_rdata (exp_rdata),
		.i_rsp       (o_rsp),
		.i_bus_error (o_bus_error),
		.i_led       (o_led),
		.i_trace_en  (o_trace_en),
		.i_genio_out (o_genio_out),
		.i_genio_oe  (o_genio_oe),
		.i_sao1_out  (o_sao1_out),
		.i_sao1_oe   (o_sao1_oe),
		.i_sao2_out  (o_sao2_out),
		.i_sao2_oe   (o_sao2_oe),
		.i_pmod_out  (o_pmod_out),
		.i_pmod_oe   (o_pmod_oe),
		.i_irda_sd   (o_irda_sd),
		.i_fsel_d    (o_fsel_d),
		.i_fsel_c    (o_fsel_c),
		.i_programn  (o_programn),
		.o_checks    (checks),
		.o_errors    (errors)
	);

	initial clk48m = 1'b0;
	always #4 clk48m = ~clk48m;

	always @(posedge clk48m) begin
		cycles++;
		if (cycles >= limit) begin
			$display("timeout, the table did not finish within %0d cycles", limit);
			$display("checks %0d errors %0d", checks, errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	function automatic word_t misc_addr(reg_idx_t idx);
		return {REGION_MISC, 21'h0, idx, 2'b00};
	endfunction

	task automatic push_step(input logic wr, input word_t addr, input word_t wdata,
			input strb_t wstrb, input logic chk, input word_t exp, input int gap);
		stim_t s;
		s.wr    = wr;
		s.addr  = addr;
		s.wdata = wdata;
		s.wstrb = wstrb;
		s.chk   = chk;
		s.exp   = exp;
		s.gap   = gap[7:0];
		stim_q.push_back(s);
	endtask

	initial begin
		seed       = 22654;
		rst        = 1'b1;
		i_req      = '0;
		exp_chk    = 1'b0;
		exp_rdata  = '0;
		i_btn      = $random(seed);
		i_genio_in = $random(seed);
		i_sao1_in  = $random(seed);
		i_sao2_in  = $random(seed);
		i_pmod_in  = $random(seed);
		i_usb_vdet = 1'b1;

		// ------------------------------------------------------------------------
		// table columns are wr, address, write data, strobes, check, expected, idle gap
		// ------------------------------------------------------------------------
		push_step(0, misc_addr(REG_LED), '0, '0, 1, 32'h0, 0);
		push_step(1, misc_addr(REG_LED), 32'h1234_A5C3, 4'hF, 0, '0, 0);
		push_step(0, misc_addr(REG_LED), '0, '0, 1, 32'h0000_A5C3, 0);
		push_step(0, misc_addr(REG_BTN), '0, '0, 1, {24'h0, ~i_btn}, 0);
		push_step(0, misc_addr(REG_SOC_VER), '0, '0, 1, 32'h0, 0);
		push_step(1, misc_addr(REG_SOC_VER), 32'h1, 4'hF, 0, '0, 0);
		push_step(0, misc_addr(REG_SOC_VER), '0, '0, 1, 32'h0, 1);
		push_step(0, misc_addr(5'd5), '0, '0, 1, 32'h0, 0);
		push_step(0, misc_addr(5'd31), '0, '0, 1, 32'h0, 0);
		// general bank plain write then set and clear
		push_step(1, misc_addr(REG_GENIO_OUT), 32'hFFFF_00F0, 4'hF, 0, '0, 0);
		push_step(1, misc_addr(REG_GENIO_W2S), 32'h0000_000F, 4'hF, 0, '0, 0);
		push_step(1, misc_addr(REG_GENIO_W2C), 32'h0F00_0001, 4'hF, 0, '0, 0);
		push_step(0, misc_addr(REG_GENIO_OUT), '0, '0, 1, 32'h30FF_00FE, 0);
		push_step(1, misc_addr(REG_GENIO_OE), 32'h2AAA_5555, 4'hF, 0, '0, 0);
		push_step(0, misc_addr(REG_GENIO_OE), '0, '0, 1, 32'h2AAA_5555, 0);
		push_step(0, misc_addr(REG_GENIO_IN), '0, '0, 1, {2'b0, i_genio_in}, 0);
		// expansion bank
		push_step(1, misc_addr(REG_GPEXT_OUT), 32'hFFFF_FFFF, 4'hF, 0, '0, 0);
		push_step(0, misc_addr(REG_GPEXT_OUT), '0, '0, 1, 32'h40FF_3F3F, 0);
		push_step(1, misc_addr(REG_GPEXT_W2C), 32'h4001_0003, 4'hF, 0, '0, 0);
		push_step(0, misc_addr(REG_GPEXT_OUT), '0, '0, 1, 32'h00FE_3F3C, 0);
		push_step(1, misc_addr(REG_GPEXT_W2S), 32'h4000_0001, 4'hF, 0, '0, 0);
		push_step(0, misc_addr(REG_GPEXT_OUT), '0, '0, 1, 32'h40FE_3F3D, 0);
		push_step(1, misc_addr(REG_GPEXT_OE), 32'hFFFF_FFFF, 4'hF, 0, '0, 0);
		push_step(0, misc_addr(REG_GPEXT_OE), '0, '0, 1, 32'h00FF_3F3F, 0);
		push_step(0, misc_addr(REG_GPEXT_IN), '0, '0, 1,
			{i_usb_vdet, 7'h0, i_pmod_in, 2'b0, i_sao2_in, 2'b0, i_sao1_in}, 0);
		// a write without the lane 0 strobe is dropped yet still returns readback
		push_step(1, misc_addr(REG_LED), 32'h0000_FFFF, 4'hE, 1, 32'h0000_A5C3, 0);
		// unmapped regions
		push_step(0, 32'h0000_0008, '0, '0, 1, BUS_ERROR_DATA, 1);
		push_step(1, 32'h3000_0000, 32'h0000_FFFF, 4'hF, 1, BUS_ERROR_DATA, 0);
		push_step(0, 32'hF000_0008, '0, '0, 1, BUS_ERROR_DATA, 0);
		push_step(0, misc_addr(REG_LED), '0, '0, 1, 32'h0000_A5C3, 0);
		// flash select pulse followed by the reload pattern
		push_step(1, misc_addr(REG_FLASH_SEL), 32'h0000_0001, 4'hF, 0, '0, 10);
		push_step(0, misc_addr(REG_FLASH_SEL), '0, '0, 1, 32'h1, 0);
		push_step(1, misc_addr(REG_FLASH_SEL), {RELOAD_MAGIC, 8'h00}, 4'hF, 0, '0, 12);
		push_step(0, misc_addr(REG_FLASH_SEL), '0, '0, 1, 32'h0, 2);
		limit = 4 * stim_q.size() + 50;

		repeat (8) @(posedge clk48m);
		#1;
		rst = 1'b0;
		foreach (stim_q[k]) begin
			@(posedge clk48m);
			#1;
			i_req.valid = 1'b1;
			i_req.addr  = stim_q[k].addr;
			i_req.wdata = stim_q[k].wr ? stim_q[k].wdata : '0;
			i_req.wstrb = stim_q[k].wr ? stim_q[k].wstrb : '0;
			exp_chk     = stim_q[k].chk;
			exp_rdata   = stim_q[k].exp;
			repeat (stim_q[k].gap) begin
				@(posedge clk48m);
				#1;
				i_req.valid = 1'b0;
			end
		end
		@(posedge clk48m);
		#1;
		i_req = '0;
		repeat (3) @(posedge clk48m);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== verilog/board_regs.sv ====
// board level registers of the misc page for leds, buttons, version and trace enable
`timescale 1ns/1ps

module board_regs
	import soc_misc_pkg::*;
(
	input  logic        clk48m,
	input  logic        rst,
	input  reg_wr_t     i_reg_wr,
	input  reg_idx_t    i_rd_idx,
	input  logic [7:0]  i_btn,
	output logic [15:0] o_led,
	output logic        o_trace_en,
	output word_t       o_rdata
);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			o_led      <= '0;
			o_trace_en <= 1'b0;
		end else if (i_reg_wr.we) begin
			if (i_reg_wr.idx == REG_LED) begin
				o_led <= i_reg_wr.wdata[15:0];
			end
			// trace enable hides behind the version register
			if (i_reg_wr.idx == REG_SOC_VER) begin
				o_trace_en <= i_reg_wr.wdata[0];
			end
		end
	end

	// buttons are active low on the board
	always_comb begin
		case (i_rd_idx)
			REG_LED:     o_rdata = {16'h0, o_led};
			REG_BTN:     o_rdata = {24'h0, ~i_btn};
			REG_SOC_VER: o_rdata = SOC_VERSION;
			default:     o_rdata = '0;
		endcase
	end

endmodule

// ==== verilog/bus_decode.sv ====
// region decoder and response stage for the misc page bus slave
// answers every request exactly one cycle later with ready and read data
`timescale 1ns/1ps

module bus_decode
	import soc_misc_pkg::*;
(
	input  logic     clk48m,
	input  logic     rst,
	input  bus_req_t i_req,
	input  word_t    i_rdata_board,
	input  word_t    i_rdata_gpio,
	input  word_t    i_rdata_fsel,
	output reg_wr_t  o_reg_wr,
	output reg_idx_t o_rd_idx,
	output bus_rsp_t o_rsp,
	output logic     o_bus_error
);

	region_e region;
	logic    hit_misc;
	word_t   rdata_merged;
	logic    rsp_ready;
	word_t   rsp_rdata;
	logic    bus_err_q;

	// ------------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------------
	assign region   = region_e'(i_req.addr[31:28]);
	assign hit_misc = (region == REGION_MISC);

	assign o_rd_idx = i_req.addr[6:2];

	// only byte lane 0 qualifies a write
	assign o_reg_wr = '{
		we:    i_req.valid && hit_misc && i_req.wstrb[0],
		idx:   i_req.addr[6:2],
		wdata: i_req.wdata
	};

	// blocks return zero for indices they do not own
	assign rdata_merged = i_rdata_board | i_rdata_gpio | i_rdata_fsel;

	// ------------------------------------------------------------------------
	// response stage
	// ------------------------------------------------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			rsp_ready <= 1'b0;
			bus_err_q <= 1'b0;
		end else begin
			rsp_ready <= i_req.valid;
			// one pulse per unmapped access
			bus_err_q <= i_req.valid && !hit_misc;
		end
	end

	always_ff @(posedge clk48m) begin
		if (i_req.valid) begin
			rsp_rdata <= hit_misc ? rdata_merged : BUS_ERROR_DATA;
		end
	end

	assign o_rsp = '{ready: rsp_ready, rdata: rsp_rdata};
	assign o_bus_error = bus_err_q;

	// the or merge needs at most one block driving readback at a time
	a_rdata_one_source: assert property (
		@(posedge clk48m) disable iff (rst)
		$onehot0({|i_rdata_board, |i_rdata_gpio, |i_rdata_fsel})
	);

endmodule

// ==== verilog/flash_sel_seq.sv ====
// flash mux select with a delayed three-cycle mux clock pulse
// the magic pattern in bits 31:8 queues an fpga reload through PROGRAMN
`timescale 1ns/1ps

module flash_sel_seq
	import soc_misc_pkg::*;
(
	input  logic     clk48m,
	input  logic     rst,
	input  reg_wr_t  i_reg_wr,
	input  reg_idx_t i_rd_idx,
	output logic     o_fsel_d,
	output logic     o_fsel_c,
	output logic     o_programn,
	output word_t    o_rdata
);

	logic       fsel_wr;
	logic       fsel_strobe;
	logic       reload_pend;
	logic       reload;
	logic [2:0] fsel_delay;

	assign fsel_wr = i_reg_wr.we && (i_reg_wr.idx == REG_FLASH_SEL);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			o_fsel_d    <= 1'b0;
			fsel_strobe <= 1'b0;
			reload_pend <= 1'b0;
		end else begin
			fsel_strobe <= fsel_wr;
			if (fsel_wr) begin
				o_fsel_d <= i_reg_wr.wdata[0];
				if (i_reg_wr.wdata[31:8] == RELOAD_MAGIC) begin
					reload_pend <= 1'b1;
				end
			end
		end
	end

	// the mux flop gets its data well before the clock edge
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_delay <= '0;
			reload     <= 1'b0;
		end else begin
			// once reloading, the sequencer stays frozen
			if (fsel_strobe && !reload) begin
				fsel_delay <= FSEL_DELAY_LOAD;
			end else if (fsel_delay != 3'd0) begin
				fsel_delay <= fsel_delay - 3'd1;
			end
			// PROGRAMN falls together with the last count
			if (fsel_delay == 3'd2 && reload_pend) begin
				reload <= 1'b1;
			end
		end
	end

	assign o_fsel_c   = (fsel_delay <= 3'd5) && (fsel_delay >= 3'd3);
	assign o_programn = ~reload;
	assign o_rdata    = (i_rd_idx == REG_FLASH_SEL) ? {31'h0, o_fsel_d} : '0;

	a_no_clk_in_reload: assert property (
		@(posedge clk48m) disable iff (rst)
		!o_programn |-> !o_fsel_c
	);

endmodule

// ==== verilog/gpio_regs.sv ====
// general i/o bank and packed expansion bank (sao1, sao2, pmod, irda shutdown)
// plain, write-to-set and write-to-clear writes plus input pin readback
`timescale 1ns/1ps

module gpio_regs
	import soc_misc_pkg::*;
(
	input  logic     clk48m,
	input  logic     rst,
	input  reg_wr_t  i_reg_wr,
	input  reg_idx_t i_rd_idx,
	input  genio_t   i_genio_in,
	input  sao_t     i_sao1_in,
	input  sao_t     i_sao2_in,
	input  pmod_t    i_pmod_in,
	input  logic     i_usb_vdet,
	output genio_t   o_genio_out,
	output genio_t   o_genio_oe,
	output sao_t     o_sao1_out,
	output sao_t     o_sao1_oe,
	output sao_t     o_sao2_out,
	output sao_t     o_sao2_oe,
	output pmod_t    o_pmod_out,
	output pmod_t    o_pmod_oe,
	output logic     o_irda_sd,
	output word_t    o_rdata
);

	// next output value for a bank with plain, set and clear registers
	function automatic word_t bank_write(word_t cur, reg_wr_t wr, reg_idx_t plain_idx,
			reg_idx_t set_idx, reg_idx_t clr_idx);
		word_t nxt;
		nxt = cur;
		if (wr.we) begin
			if (wr.idx == plain_idx) begin
				nxt = wr.wdata;
			end else if (wr.idx == set_idx) begin
				nxt = cur | wr.wdata;
			end else if (wr.idx == clr_idx) begin
				nxt = cur & ~wr.wdata;
			end
		end
		return nxt;
	endfunction

	// expansion bank kept in bus layout
	word_t ext_out_q;
	word_t ext_oe_q;
	word_t ext_in;
	word_t genio_nx;
	word_t ext_nx;

	assign genio_nx = bank_write({2'b0, o_genio_out}, i_reg_wr, REG_GENIO_OUT,
		REG_GENIO_W2S, REG_GENIO_W2C);
	assign ext_nx = bank_write(ext_out_q, i_reg_wr, REG_GPEXT_OUT,
		REG_GPEXT_W2S, REG_GPEXT_W2C);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			o_genio_out <= '0;
			o_genio_oe  <= '0;
			ext_out_q   <= GPEXT_OUT_RESET;
			ext_oe_q    <= '0;
		end else begin
			o_genio_out <= genio_nx[$bits(genio_t)-1:0];
			ext_out_q   <= ext_nx & GPEXT_OUT_MASK;
			if (i_reg_wr.we && i_reg_wr.idx == REG_GENIO_OE) begin
				o_genio_oe <= i_reg_wr.wdata[$bits(genio_t)-1:0];
			end
			if (i_reg_wr.we && i_reg_wr.idx == REG_GPEXT_OE) begin
				ext_oe_q <= i_reg_wr.wdata & GPEXT_OE_MASK;
			end
		end
	end

	assign o_sao1_out = ext_out_q[SAO1_LSB +: $bits(sao_t)];
	assign o_sao2_out = ext_out_q[SAO2_LSB +: $bits(sao_t)];
	assign o_pmod_out = ext_out_q[PMOD_LSB +: $bits(pmod_t)];
	assign o_irda_sd  = ext_out_q[IRDA_SD_BIT];
	assign o_sao1_oe  = ext_oe_q[SAO1_LSB +: $bits(sao_t)];
	assign o_sao2_oe  = ext_oe_q[SAO2_LSB +: $bits(sao_t)];
	assign o_pmod_oe  = ext_oe_q[PMOD_LSB +: $bits(pmod_t)];

	// input pins in the same layout, vbus detect on top
	always_comb begin
		ext_in = '0;
		ext_in[SAO1_LSB +: $bits(sao_t)]  = i_sao1_in;
		ext_in[SAO2_LSB +: $bits(sao_t)]  = i_sao2_in;
		ext_in[PMOD_LSB +: $bits(pmod_t)] = i_pmod_in;
		ext_in[USB_VDET_BIT]              = i_usb_vdet;
	end

	always_comb begin
		case (i_rd_idx)
			REG_GENIO_IN:  o_rdata = {2'b0, i_genio_in};
			REG_GENIO_OUT: o_rdata = {2'b0, o_genio_out};
			REG_GENIO_OE:  o_rdata = {2'b0, o_genio_oe};
			REG_GPEXT_IN:  o_rdata = ext_in;
			REG_GPEXT_OUT: o_rdata = ext_out_q;
			REG_GPEXT_OE:  o_rdata = ext_oe_q;
			default:       o_rdata = '0;
		endcase
	end

endmodule

// ==== verilog/soc_misc_pkg.sv ====
// shared bus types, register map and constants for the misc control page
// imported by wildcard into each design module that needs them
package soc_misc_pkg;

	// ------------------------------------------------------------------------
	// widths and bus types
	// ------------------------------------------------------------------------
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [29:0] genio_t;
	typedef logic [5:0]  sao_t;
	typedef logic [7:0]  pmod_t;

	// region code from address bits 31:28 where only the misc page is mapped
	typedef enum logic [3:0] {
		REGION_BOOT = 4'h0,
		REGION_UART = 4'h1,
		REGION_MISC = 4'h2,
		REGION_LCD  = 4'h3,
		REGION_RAM  = 4'h4
	} region_e;

	typedef struct packed {
		logic  valid;
		word_t addr;
		word_t wdata;
		strb_t wstrb;
	} bus_req_t;

	typedef struct packed {
		logic  ready;
		word_t rdata;
	} bus_rsp_t;

	// write strobe from the decoder to the register blocks
	typedef struct packed {
		logic     we;
		reg_idx_t idx;
		word_t    wdata;
	} reg_wr_t;

	// ------------------------------------------------------------------------
	// misc page register indices (address bits 6:2)
	// ------------------------------------------------------------------------
	localparam reg_idx_t REG_LED       = 5'd0;
	localparam reg_idx_t REG_BTN       = 5'd1;
	localparam reg_idx_t REG_SOC_VER   = 5'd2;
	localparam reg_idx_t REG_FLASH_SEL = 5'd13;
	localparam reg_idx_t REG_GENIO_IN  = 5'd17;
	localparam reg_idx_t REG_GENIO_OUT = 5'd18;
	localparam reg_idx_t REG_GENIO_OE  = 5'd19;
	localparam reg_idx_t REG_GENIO_W2S = 5'd20;
	localparam reg_idx_t REG_GENIO_W2C = 5'd21;
	localparam reg_idx_t REG_GPEXT_IN  = 5'd22;
	localparam reg_idx_t REG_GPEXT_OUT = 5'd23;
	localparam reg_idx_t REG_GPEXT_OE  = 5'd24;
	localparam reg_idx_t REG_GPEXT_W2S = 5'd25;
	localparam reg_idx_t REG_GPEXT_W2C = 5'd26;

	// ------------------------------------------------------------------------
	// constants
	// ------------------------------------------------------------------------
	localparam word_t       BUS_ERROR_DATA  = 32'hDEAD_BEEF;
	localparam word_t       SOC_VERSION     = 32'h0000_0000;
	localparam logic [23:0] RELOAD_MAGIC    = 24'hD0F1A5;
	localparam logic [2:0]  FSEL_DELAY_LOAD = 3'd7;

	// expansion word layout
	localparam int SAO1_LSB     = 0;
	localparam int SAO2_LSB     = 8;
	localparam int PMOD_LSB     = 16;
	localparam int IRDA_SD_BIT  = 30;
	localparam int USB_VDET_BIT = 31;

	localparam word_t GPEXT_OUT_MASK  = 32'h40FF_3F3F;
	localparam word_t GPEXT_OE_MASK   = 32'h00FF_3F3F;
	// irda transceiver starts in shutdown
	localparam word_t GPEXT_OUT_RESET = 32'h4000_0000;

endpackage

// ==== verilog/soc_misc_top.sv ====
// misc control page of the badge soc built from the decoder and the board, gpio and
// flash-select blocks
`timescale 1ns/1ps

module soc_misc_top
	import soc_misc_pkg::*;
(
	input  logic        clk48m,
	input  logic        rst,
	input  bus_req_t    i_req,
	input  logic [7:0]  i_btn,
	input  genio_t      i_genio_in,
	input  sao_t        i_sao1_in,
	input  sao_t        i_sao2_in,
	input  pmod_t       i_pmod_in,
	input  logic        i_usb_vdet,
	output bus_rsp_t    o_rsp,
	output logic        o_bus_error,
	output logic [15:0] o_led,
	output logic        o_trace_en,
	output genio_t      o_genio_out,
	output genio_t      o_genio_oe,
	output sao_t        o_sao1_out,
	output sao_t        o_sao1_oe,
	output sao_t        o_sao2_out,
	output sao_t        o_sao2_oe,
	output pmod_t       o_pmod_out,
	output pmod_t       o_pmod_oe,
	output logic        o_irda_sd,
	output logic        o_fsel_d,
	output logic        o_fsel_c,
	output logic        o_programn
);

	reg_wr_t  reg_wr;
	reg_idx_t rd_idx;
	word_t    rdata_board;
	word_t    rdata_gpio;
	word_t    rdata_fsel;

	// ------------------------------------------------------------------------
	// bus side
	// ------------------------------------------------------------------------
	bus_decode u_bus_decode (
		.clk48m        (clk48m),
		.rst           (rst),
		.i_req         (i_req),
		.i_rdata_board (rdata_board),
		.i_rdata_gpio  (rdata_gpio),
		.i_rdata_fsel  (rdata_fsel),
		.o_reg_wr      (reg_wr),
		.o_rd_idx      (rd_idx),
		.o_rsp         (o_rsp),
		.o_bus_error   (o_bus_error)
	);

	// ------------------------------------------------------------------------
	// register blocks
	// ------------------------------------------------------------------------
	board_regs u_board_regs (
		.clk48m     (clk48m),
		.rst        (rst),
		.i_reg_wr   (reg_wr),
		.i_rd_idx   (rd_idx),
		.i_btn      (i_btn),
		.o_led      (o_led),
		.o_trace_en (o_trace_en),
		.o_rdata    (rdata_board)
	);

	gpio_regs u_gpio_regs (
		.clk48m      (clk48m),
		.rst         (rst),
		.i_reg_wr    (reg_wr),
		.i_rd_idx    (rd_idx),
		.i_genio_in  (i_genio_in),
		.i_sao1_in   (i_sao1_in),
		.i_sao2_in   (i_sao2_in),
		.i_pmod_in   (i_pmod_in),
		.i_usb_vdet  (i_usb_vdet),
		.o_genio_out (o_genio_out),
		.o_genio_oe  (o_genio_oe),
		.o_sao1_out  (o_sao1_out),
		.o_sao1_oe   (o_sao1_oe),
		.o_sao2_out  (o_sao2_out),
		.o_sao2_oe   (o_sao2_oe),
		.o_pmod_out  (o_pmod_out),
		.o_pmod_oe   (o_pmod_oe),
		.o_irda_sd   (o_irda_sd),
		.o_rdata     (rdata_gpio)
	);

	flash_sel_seq u_flash_sel_seq (
		.clk48m     (clk48m),
		.rst        (rst),
		.i_reg_wr   (reg_wr),
		.i_rd_idx   (rd_idx),
		.o_fsel_d   (o_fsel_d),
		.o_fsel_c   (o_fsel_c),
		.o_programn (o_programn),
		.o_rdata    (rdata_fsel)
	);

endmodule
